//--- Makefile
# Verilator flow for the fetch unit: lint the RTL, build and run the testbench

VERILATOR ?= verilator
RTL_TOP   ?= fetch_top
TB_TOP    ?= fetch_tb
FILELIST  ?= fetch_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
RTL_FILES ?= design/fetch_pkg.sv design/fetch_bht.sv design/fetch_btb.sv \
             design/fetch_pc.sv design/fetch_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code
sim: build
	-$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/fetch_assert.sv
// fetch output assertions, bound into the pc stage
`timescale 1ns/1ps

module fetch_assert
(
	input logic                          clock,
	input logic                          reset,
	input logic [fetch_pkg::pc_width-1:0] pc0,
	input logic [fetch_pkg::pc_width-1:0] pc1,
	input logic                          valid0,
	input logic                          valid1
);

	////////////////////
	// slot rules
	////////////////////
	// slot 1 never stands alone
	a_valid1_needs_valid0 : assert property (@(posedge clock) disable iff (reset)
		valid1 |-> valid0)
		else $error("valid1 high while valid0 low");

	// a second slot only exists on an aligned pc
	a_valid1_aligned : assert property (@(posedge clock) disable iff (reset)
		valid1 |-> (pc0[2] == 1'b0))
		else $error("valid1 high on a misaligned pc0");

	////////////////////
	// reset and pcs
	////////////////////
	a_quiet_in_reset : assert property (@(posedge clock)
		reset |-> (!valid0 && !valid1))
		else $error("valid output high during reset");

	a_pc1_follows : assert property (@(posedge clock) disable iff (reset)
		pc1 == pc0 + 64'd4)  // slot 1 is the next word
		else $error("pc1 is not pc0 plus 4");

endmodule

bind fetch_pc fetch_assert chk
(
	.clock(clock),
	.reset(reset),
	.pc0(pc0),
	.pc1(pc1),
	.valid0(valid0),
	.valid1(valid1)
);

//--- bench/fetch_tb.sv
// fetch unit testbench: clock, reset, memory model, stimulus, reference predictor, checks, watchdog
`timescale 1ns/1ps

module fetch_tb;

	localparam int directed_cycles = 100;  // upper bound for the directed part
	localparam int random_cycles   = 300;

	logic                               clock;
	logic                               reset;
	logic [2*fetch_pkg::inst_width-1:0] imem_data;
	logic                               imem_valid;
	logic [fetch_pkg::pc_width-1:0]     imem_addr;
	logic [1:0]                         accept;
	logic [fetch_pkg::inst_width-1:0]   inst0;
	logic [fetch_pkg::inst_width-1:0]   inst1;
	logic [fetch_pkg::pc_width-1:0]     pc0;
	logic [fetch_pkg::pc_width-1:0]     pc1;
	logic                               valid0;
	logic                               valid1;
	logic                               redirect;
	logic [fetch_pkg::pc_width-1:0]     redirect_pc;
	logic                               resolve_valid;
	logic [fetch_pkg::pc_width-1:0]     resolve_pc;
	logic                               resolve_taken;
	logic [fetch_pkg::pc_width-1:0]     resolve_target;
	fetch_pkg::fetch_line_u             mem_line;     // memory answer for imem_addr

	// reference predictor state
	logic [fetch_pkg::pc_width-1:0]     ref_pc;
	logic [1:0]                         ref_ctr    [64];
	logic                               ref_live   [32];  // btb valid bits
	logic [fetch_pkg::btb_tag_bits-1:0] ref_tag    [32];
	logic [fetch_pkg::pc_width-1:0]     ref_target [32];

	int inst_errors  = 0;
	int pc_errors    = 0;
	int valid_errors = 0;

	fetch_top UUT (.clock(clock), .reset(reset), .imem_data(imem_data),
		.imem_valid(imem_valid), .imem_addr(imem_addr), .accept(accept), .inst0(inst0),
		.inst1(inst1), .pc0(pc0), .pc1(pc1), .valid0(valid0), .valid1(valid1),
		.redirect(redirect), .redirect_pc(redirect_pc), .resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc), .resolve_taken(resolve_taken),
		.resolve_target(resolve_target));

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;  // 10 ns period
	end

	////////////////////
	// memory model
	////////////////////
	// scrambled word, every address bit matters
	function automatic logic [fetch_pkg::inst_width-1:0] word_at(
		input logic [fetch_pkg::pc_width-1:0] a);
		return (a[31:0] ^ a[63:32] ^ 32'h5a5a_0f0f) * 32'h9e37_79b1;
	endfunction

	function automatic fetch_pkg::fetch_line_u line_at(input logic [fetch_pkg::pc_width-1:0] a);
		fetch_pkg::fetch_line_u l;
		l.slot[0] = word_at(a);            // lower word, line address
		l.slot[1] = word_at(a + 64'd4);
		return l;
	endfunction

	assign mem_line  = line_at(imem_addr);
	assign imem_data = mem_line.whole;   // same cycle answer

	////////////////////
	// reference model
	////////////////////
	task automatic reset_ref();
		ref_pc = '0;
		for (int i = 0; i < 64; i++)
			ref_ctr[i] = 2'b01;  // weakly not taken
		for (int i = 0; i < 32; i++)
			ref_live[i] = 1'b0;
	endtask

	// counters saturate at 0 and 3, only taken branches fill the btb
	task automatic train_tables();
		logic [5:0] ci;
		logic [4:0] bi;
		ci = resolve_pc[7:2];
		bi = resolve_pc[6:2];
		if (resolve_valid)
		begin
			if (resolve_taken && ref_ctr[ci] != 2'd3)
				ref_ctr[ci] = ref_ctr[ci] + 2'd1;
			else if (!resolve_taken && ref_ctr[ci] != 2'd0)
				ref_ctr[ci] = ref_ctr[ci] - 2'd1;
			if (resolve_taken)
			begin
				ref_live[bi]   = 1'b1;
				ref_tag[bi]    = resolve_pc[63:7];
				ref_target[bi] = resolve_target;
			end
		end
	endtask

	// taken needs counter >= 2 and a matching btb entry
	function automatic logic slot_predicted(input logic [fetch_pkg::pc_width-1:0] pc,
		output logic [fetch_pkg::pc_width-1:0] tgt);
		logic [5:0] ci;
		logic [4:0] bi;
		ci  = pc[7:2];
		bi  = pc[6:2];
		tgt = ref_target[bi];
		return (ref_ctr[ci] >= 2'd2) && ref_live[bi] && (ref_tag[bi] == pc[63:7]);
	endfunction

	function automatic void expect_fetch(
		input  logic [fetch_pkg::pc_width-1:0] pc,
		input  logic                           mem_ok,
		input  logic                           rst,
		input  logic [1:0]                     acc,
		input  logic                           redir,
		input  logic [fetch_pkg::pc_width-1:0] redir_pc,
		output logic                           v0,
		output logic                           v1,
		output logic [fetch_pkg::pc_width-1:0] npc);
		logic                           p0;
		logic                           p1;
		logic [fetch_pkg::pc_width-1:0] t0;
		logic [fetch_pkg::pc_width-1:0] t1;
		p0 = slot_predicted(pc, t0);
		p1 = slot_predicted(pc + 64'd4, t1);
		v0 = mem_ok && !rst;
		v1 = v0 && !pc[2] && !p0;  // killed behind a taken slot 0
		if (redir)
			npc = redir_pc;
		else if (acc == 2'd0 || !v0)
			npc = pc;                            // hold
		else if (v1 && acc >= 2'd2)
			npc = p1 ? t1 : pc + 64'd8;          // both slots leave
		else
			npc = p0 ? t0 : pc + 64'd4;
	endfunction

	////////////////////
	// compare tasks
	////////////////////
	task automatic inst_check(input string what, input logic [fetch_pkg::inst_width-1:0] got,
		input logic [fetch_pkg::inst_width-1:0] exp);
		if (got !== exp)
		begin
			inst_errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic pc_check(input string what, input logic [fetch_pkg::pc_width-1:0] got,
		input logic [fetch_pkg::pc_width-1:0] exp);
		if (got !== exp)
		begin
			pc_errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic valid_check(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			valid_errors++;
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// outputs settle mid cycle, state moves on the rising edge
	initial
	begin : compare_outputs
		logic                           e_v0;
		logic                           e_v1;
		logic [fetch_pkg::pc_width-1:0] e_next;
		reset_ref();
		forever
		begin
			@(negedge clock);
			expect_fetch(ref_pc, imem_valid, reset, accept, redirect, redirect_pc,
				e_v0, e_v1, e_next);
			valid_check("valid0", valid0, e_v0);
			valid_check("valid1", valid1, e_v1);
			if (!reset)
			begin
				pc_check("pc0", pc0, ref_pc);
				pc_check("imem_addr", imem_addr, {ref_pc[63:3], 3'b000});
				if (e_v0)
					inst_check("inst0", inst0, word_at(ref_pc));
				if (e_v1)
				begin
					inst_check("inst1", inst1, word_at(ref_pc + 64'd4));
					pc_check("pc1", pc1, ref_pc + 64'd4);
				end
			end
			@(posedge clock);
			if (reset)
				reset_ref();
			else
			begin
				ref_pc = e_next;
				train_tables();
			end
		end
	end

	////////////////////
	// stimulus
	////////////////////
	task automatic next_cycle();
		@(posedge clock);
		#1;  // drive just after the edge
	endtask

	task automatic redirect_to(input logic [fetch_pkg::pc_width-1:0] target);
		redirect    = 1'b1;
		redirect_pc = target;
		next_cycle();
		redirect    = 1'b0;
	endtask

	task automatic resolve_branch(input logic [fetch_pkg::pc_width-1:0] pc, input logic taken,
		input logic [fetch_pkg::pc_width-1:0] target);
		resolve_valid  = 1'b1;
		resolve_pc     = pc;
		resolve_taken  = taken;
		resolve_target = target;
		next_cycle();
		resolve_valid  = 1'b0;
	endtask

	initial
	begin
		void'($urandom(83));
		reset          = 1'b1;
		imem_valid     = 1'b1;  // memory ready in reset, valids stay low anyway
		accept         = 2'd0;
		redirect       = 1'b0;
		redirect_pc    = '0;
		resolve_valid  = 1'b0;
		resolve_pc     = '0;
		resolve_taken  = 1'b0;
		resolve_target = '0;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;

		// sequential fetch, aligned then misaligned
		accept     = 2'd2;
		imem_valid = 1'b1;
		repeat (6) next_cycle();
		redirect_to(64'h104);
		repeat (4) next_cycle();

		// back-pressure
		accept = 2'd0;
		repeat (3) next_cycle();
		accept = 2'd1;
		repeat (3) next_cycle();
		accept = 2'd2;

		// memory not ready
		imem_valid = 1'b0;
		repeat (3) next_cycle();
		imem_valid = 1'b1;

		// redirect wins over a stall
		accept = 2'd0;
		redirect_to(64'h200);
		repeat (2) next_cycle();
		accept = 2'd2;
		repeat (2) next_cycle();

		// train a slot 0 branch, then fetch it
		resolve_branch(64'h300, 1'b1, 64'h388);
		resolve_branch(64'h300, 1'b1, 64'h388);
		redirect_to(64'h300);
		repeat (3) next_cycle();

		// slot 1 branch, reached one slot at a time and then as a pair
		resolve_branch(64'h504, 1'b1, 64'h600);
		resolve_branch(64'h504, 1'b1, 64'h600);
		redirect_to(64'h500);
		accept = 2'd1;
		repeat (2) next_cycle();
		accept = 2'd2;
		redirect_to(64'h500);
		repeat (3) next_cycle();

		// untrain slot 0 branch, counter 3 -> 2 -> 1
		resolve_branch(64'h300, 1'b0, 64'h0);
		redirect_to(64'h300);
		repeat (2) next_cycle();
		resolve_branch(64'h300, 1'b0, 64'h0);
		redirect_to(64'h300);
		repeat (3) next_cycle();

		// btb alias at the same index, other tag
		resolve_branch(64'h300, 1'b1, 64'h388);
		resolve_branch(64'h300, 1'b1, 64'h388);
		redirect_to(64'h300);
		repeat (2) next_cycle();
		resolve_branch(64'h1300, 1'b1, 64'h700);
		redirect_to(64'h300);
		repeat (3) next_cycle();
		redirect_to(64'h1300);
		repeat (2) next_cycle();

		// random mix over a small window of word addresses
		for (int n = 0; n < random_cycles; n++)
		begin
			accept         = 2'($urandom % 3);
			imem_valid     = ($urandom % 8) != 0;
			redirect       = ($urandom % 12) == 0;
			redirect_pc    = 64'($urandom % 512) << 2;
			resolve_valid  = ($urandom % 3) == 0;
			resolve_pc     = 64'($urandom % 512) << 2;
			resolve_taken  = ($urandom % 2) == 1;
			resolve_target = 64'($urandom % 512) << 2;
			next_cycle();
		end
		redirect      = 1'b0;
		resolve_valid = 1'b0;
		repeat (2) next_cycle();

		$display("errors: inst %0d, pc %0d, valid %0d", inst_errors, pc_errors, valid_errors);
		if (inst_errors + pc_errors + valid_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	////////////////////
	// watchdog
	////////////////////
	initial
	begin : watchdog
		#((directed_cycles + random_cycles) * 10 + 200);
		$display("timeout: the stimulus did not finish in the expected time");
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- design/fetch_bht.sv
// branch history table: two-bit saturating counters, two read ports, one training port
`timescale 1ns/1ps

module fetch_bht
(
	input  logic                          clock,
	input  logic                          reset,
	input  logic [fetch_pkg::pc_width-1:0] lookup_pc0,     // slot 0 pc
	input  logic [fetch_pkg::pc_width-1:0] lookup_pc1,     // slot 1 pc
	input  logic                          resolve_valid,  // pulse from execute
	input  logic [fetch_pkg::pc_width-1:0] resolve_pc,
	input  logic                          resolve_taken,
	output logic                          taken0,         // counter says taken
	output logic                          taken1
);

	// counter array, one per word index
	logic [1:0] ctr [fetch_pkg::bht_entries];

	logic [fetch_pkg::bht_index_bits-1:0] rd_idx0;
	logic [fetch_pkg::bht_index_bits-1:0] rd_idx1;
	logic [fetch_pkg::bht_index_bits-1:0] wr_idx;
	logic [1:0]                           ctr_cur;   // counter being trained
	logic [1:0]                           ctr_next;  // its updated value

	////////////////////
	// lookup
	////////////////////
	assign rd_idx0 = fetch_pkg::bht_index(lookup_pc0);
	assign rd_idx1 = fetch_pkg::bht_index(lookup_pc1);

	// msb set means 2 or 3, predict taken
	assign taken0 = ctr[rd_idx0][1];
	assign taken1 = ctr[rd_idx1][1];

	////////////////////
	// training
	////////////////////
	assign wr_idx  = fetch_pkg::bht_index(resolve_pc);
	assign ctr_cur = ctr[wr_idx];

	always_comb
	begin
		ctr_next = ctr_cur;
		if (resolve_taken)
		begin
			if (ctr_cur != 2'b11)
				ctr_next = ctr_cur + 2'd1;  // count up, stop at 3
		end
		else
		begin
			if (ctr_cur != 2'b00)
				ctr_next = ctr_cur - 2'd1;  // count down, stop at 0
		end
	end

	// every resolve trains, taken or not
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < fetch_pkg::bht_entries; i++)
				ctr[i] <= fetch_pkg::ctr_reset;  // all weakly not taken
		end
		else if (resolve_valid)
		begin
			ctr[wr_idx] <= ctr_next;
		end
	end

endmodule

//--- design/fetch_btb.sv
// branch target buffer: direct mapped, tagged entries, two lookup ports, one write port
`timescale 1ns/1ps

module fetch_btb
(
	input  logic                          clock,
	input  logic                          reset,
	input  logic [fetch_pkg::pc_width-1:0] lookup_pc0,
	input  logic [fetch_pkg::pc_width-1:0] lookup_pc1,
	input  logic                          resolve_valid,   // pulse from execute
	input  logic [fetch_pkg::pc_width-1:0] resolve_pc,
	input  logic                          resolve_taken,   // only taken branches fill
	input  logic [fetch_pkg::pc_width-1:0] resolve_target,
	output logic                          hit0,
	output logic                          hit1,
	output logic [fetch_pkg::pc_width-1:0] target0,         // meaningful only on hit0
	output logic [fetch_pkg::pc_width-1:0] target1
);

	////////////////////
	// storage
	////////////////////
	logic                               entry_valid  [fetch_pkg::btb_entries];
	logic [fetch_pkg::btb_tag_bits-1:0] entry_tag    [fetch_pkg::btb_entries];
	logic [fetch_pkg::pc_width-1:0]     entry_target [fetch_pkg::btb_entries];

	logic [fetch_pkg::btb_index_bits-1:0] rd_idx0;
	logic [fetch_pkg::btb_index_bits-1:0] rd_idx1;
	logic [fetch_pkg::btb_index_bits-1:0] wr_idx;
	logic                                 wr_en;

	assign rd_idx0 = fetch_pkg::btb_index(lookup_pc0);
	assign rd_idx1 = fetch_pkg::btb_index(lookup_pc1);
	assign wr_idx  = fetch_pkg::btb_index(resolve_pc);

	// a not-taken resolve leaves the entry alone
	assign wr_en = resolve_valid & resolve_taken;

	////////////////////
	// lookup
	////////////////////
	// hit needs a live entry whose tag matches the upper pc bits
	assign hit0 = entry_valid[rd_idx0] &&
		(entry_tag[rd_idx0] == fetch_pkg::btb_tag(lookup_pc0));
	assign hit1 = entry_valid[rd_idx1] &&
		(entry_tag[rd_idx1] == fetch_pkg::btb_tag(lookup_pc1));

	assign target0 = entry_target[rd_idx0];
	assign target1 = entry_target[rd_idx1];

	////////////////////
	// update
	////////////////////
	// valid bits clear on reset
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < fetch_pkg::btb_entries; i++)
				entry_valid[i] <= 1'b0;
		end
		else if (wr_en)
		begin
			entry_valid[wr_idx] <= 1'b1;
		end
	end

	// tag and target just overwrite, an alias at the same index evicts the old branch
	always_ff @(posedge clock)
	begin
		if (wr_en)
		begin
			entry_tag[wr_idx]    <= fetch_pkg::btb_tag(resolve_pc);
			entry_target[wr_idx] <= resolve_target;
		end
	end

endmodule

//--- design/fetch_pc.sv
// fetch pc stage: pc register, slot select and validity, taken kill, next-pc mux
`timescale 1ns/1ps

module fetch_pc
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic [2*fetch_pkg::inst_width-1:0] imem_data,    // aligned line for imem_addr
	input  logic                              imem_valid,
	input  logic [1:0]                        accept,       // how many slots downstream takes
	input  logic                              redirect,     // pulse from execute
	input  logic [fetch_pkg::pc_width-1:0]     redirect_pc,
	input  logic                              taken0,       // bht says taken
	input  logic                              taken1,
	input  logic                              hit0,         // btb has a target
	input  logic                              hit1,
	input  logic [fetch_pkg::pc_width-1:0]     target0,
	input  logic [fetch_pkg::pc_width-1:0]     target1,
	output logic [fetch_pkg::pc_width-1:0]     imem_addr,
	output logic [fetch_pkg::pc_width-1:0]     lookup_pc0,   // to both tables
	output logic [fetch_pkg::pc_width-1:0]     lookup_pc1,
	output logic [fetch_pkg::inst_width-1:0]   inst0,
	output logic [fetch_pkg::inst_width-1:0]   inst1,
	output logic [fetch_pkg::pc_width-1:0]     pc0,
	output logic [fetch_pkg::pc_width-1:0]     pc1,
	output logic                              valid0,
	output logic                              valid1
);

	logic [fetch_pkg::pc_width-1:0] pc_reg;      // address being fetched
	logic [fetch_pkg::pc_width-1:0] pc_plus_4;
	logic [fetch_pkg::pc_width-1:0] pc_plus_8;
	logic [fetch_pkg::pc_width-1:0] next_pc;
	fetch_pkg::fetch_line_u         line;        // memory word, split into slots
	logic                           pred0;       // slot 0 predicted taken
	logic                           pred1;
	logic                           take_two;    // both slots leave this cycle

	////////////////////
	// address and slots
	////////////////////
	assign pc_plus_4 = pc_reg + 64'd4;
	assign pc_plus_8 = pc_reg + 64'd8;

	assign imem_addr = {pc_reg[fetch_pkg::pc_width-1:3], 3'b000};  // line aligned

	assign line.whole = imem_data;

	// bit 2 picks the upper word when the pc sits in the middle of a line
	assign inst0 = pc_reg[2] ? line.slot[1] : line.slot[0];
	assign inst1 = line.slot[1];  // only valid when pc is aligned

	assign pc0 = pc_reg;
	assign pc1 = pc_plus_4;

	assign lookup_pc0 = pc_reg;
	assign lookup_pc1 = pc_plus_4;

	////////////////////
	// prediction, validity
	////////////////////
	// counter and btb must agree before we jump
	assign pred0 = taken0 & hit0;
	assign pred1 = taken1 & hit1;

	assign valid0 = imem_valid & ~reset;

	// slot 1 needs an aligned pc and no taken branch ahead of it
	assign valid1 = valid0 & ~pc_reg[2] & ~pred0;

	// accept of 2 or more with two live slots
	assign take_two = valid1 & accept[1];

	////////////////////
	// next pc
	////////////////////
	always_comb
	begin
		if (redirect)
			next_pc = redirect_pc;                   // execute wins over everything
		else if (accept == 2'd0 || !valid0)
			next_pc = pc_reg;                        // stall or memory not ready
		else if (take_two)
			next_pc = pred1 ? target1 : pc_plus_8;   // last taken slot is slot 1
		else
			next_pc = pred0 ? target0 : pc_plus_4;   // only slot 0 leaves
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			pc_reg <= fetch_pkg::reset_pc;
		else
			pc_reg <= next_pc;
	end

endmodule

//--- design/fetch_pkg.sv
// fetch package: sizes, reset values, the memory line union and table index helpers
package fetch_pkg;

	////////////////////
	// widths and sizes
	////////////////////
	localparam int pc_width       = 64;   // full Alpha PC
	localparam int inst_width     = 32;   // one instruction word
	localparam int bht_index_bits = 6;    // 64 counters, pc[7:2]
	localparam int btb_index_bits = 5;    // 32 entries, pc[6:2]
	localparam int bht_entries    = 1 << bht_index_bits;
	localparam int btb_entries    = 1 << btb_index_bits;
	// tag is everything above the index and the byte offset
	localparam int btb_tag_bits   = pc_width - btb_index_bits - 2;

	localparam logic [pc_width-1:0] reset_pc  = '0;     // first fetch address
	localparam logic [1:0]          ctr_reset = 2'b01;  // weakly not taken

	////////////////////
	// memory line
	////////////////////
	// one aligned doubleword from instruction memory
	// slot[0] is the word at the line address, slot[1] the word at +4
	typedef union packed {
		logic [2*inst_width-1:0]        whole;  // as returned by the memory
		logic [1:0][inst_width-1:0]     slot;   // as two instruction words
	} fetch_line_u;

	////////////////////
	// pc field helpers
	////////////////////
	function automatic logic [bht_index_bits-1:0] bht_index(input logic [pc_width-1:0] pc);
		return pc[bht_index_bits+1:2];  // word index, low bits
	endfunction

	function automatic logic [btb_index_bits-1:0] btb_index(input logic [pc_width-1:0] pc);
		return pc[btb_index_bits+1:2];
	endfunction

	// upper pc bits, compared on every btb lookup
	function automatic logic [btb_tag_bits-1:0] btb_tag(input logic [pc_width-1:0] pc);
		return pc[pc_width-1:btb_index_bits+2];
	endfunction

endpackage

//--- design/fetch_top.sv
// fetch unit top: pc stage wired to branch history table and branch target buffer
`timescale 1ns/1ps

module fetch_top
(
	input  logic                              clock,
	input  logic                              reset,
	// instruction memory
	input  logic [2*fetch_pkg::inst_width-1:0] imem_data,
	input  logic                              imem_valid,
	output logic [fetch_pkg::pc_width-1:0]     imem_addr,
	// downstream
	input  logic [1:0]                        accept,
	output logic [fetch_pkg::inst_width-1:0]   inst0,
	output logic [fetch_pkg::inst_width-1:0]   inst1,
	output logic [fetch_pkg::pc_width-1:0]     pc0,
	output logic [fetch_pkg::pc_width-1:0]     pc1,
	output logic                              valid0,
	output logic                              valid1,
	// from execute
	input  logic                              redirect,
	input  logic [fetch_pkg::pc_width-1:0]     redirect_pc,
	input  logic                              resolve_valid,
	input  logic [fetch_pkg::pc_width-1:0]     resolve_pc,
	input  logic                              resolve_taken,
	input  logic [fetch_pkg::pc_width-1:0]     resolve_target
);

	logic [fetch_pkg::pc_width-1:0] lookup_pc0;   // pc stage to tables
	logic [fetch_pkg::pc_width-1:0] lookup_pc1;
	logic                           taken0;       // bht to pc stage
	logic                           taken1;
	logic                           hit0;         // btb to pc stage
	logic                           hit1;
	logic [fetch_pkg::pc_width-1:0] target0;
	logic [fetch_pkg::pc_width-1:0] target1;

	////////////////////
	// pc stage
	////////////////////
	fetch_pc pc_stage (.clock(clock), .reset(reset), .imem_data(imem_data),
		.imem_valid(imem_valid), .accept(accept), .redirect(redirect),
		.redirect_pc(redirect_pc), .taken0(taken0), .taken1(taken1), .hit0(hit0),
		.hit1(hit1), .target0(target0), .target1(target1), .imem_addr(imem_addr),
		.lookup_pc0(lookup_pc0), .lookup_pc1(lookup_pc1), .inst0(inst0), .inst1(inst1),
		.pc0(pc0), .pc1(pc1), .valid0(valid0), .valid1(valid1));

	////////////////////
	// predictors
	////////////////////
	// both trained straight from the resolve port
	fetch_bht bht (.clock(clock), .reset(reset), .lookup_pc0(lookup_pc0),
		.lookup_pc1(lookup_pc1), .resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken), .taken0(taken0), .taken1(taken1));

	fetch_btb btb (.clock(clock), .reset(reset), .lookup_pc0(lookup_pc0),
		.lookup_pc1(lookup_pc1), .resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken), .resolve_target(resolve_target),
		.hit0(hit0), .hit1(hit1), .target0(target0), .target1(target1));

endmodule

//--- fetch_top.f
design/fetch_pkg.sv
design/fetch_bht.sv
design/fetch_btb.sv
design/fetch_pc.sv
design/fetch_top.sv
bench/fetch_assert.sv
bench/fetch_tb.sv
